// File: divDecode.sv
`default_nettype none
`timescale 1ns/1ps

`include "div_params.svh"

module divDecode
(
	input wire logic clk,
	input wire logic rst,
	input wire logic cmdStrobe,
	input wire divPkg::divCmd_u cmd,
	input wire logic busy,
	output divPkg::divJob_t job,
	output logic go
);

	logic [`DIV_WIDTH-1:0] dividendReg;
	logic [`DIV_WIDTH-1:0] divisorReg;
	logic isLoadA;
	logic isLoadB;
	logic isDivide;
	logic accept;
	logic signedMode;
	logic dividendNeg;
	logic divisorNeg;
	divPkg::divJob_t nextJob;

	always_comb
	begin
		isLoadA = cmdStrobe && (cmd.load.opcode == `DIV_OP_LOADA);
		isLoadB = cmdStrobe && (cmd.load.opcode == `DIV_OP_LOADB);
		isDivide = cmdStrobe && (cmd.start.opcode == `DIV_OP_DIVIDE);
		// A divide on the cycle after an accepted one would slip in before busy rises.
		accept = isDivide && !busy && !go;
	end

	always_comb
	begin
		signedMode = cmd.start.signedMode;
		dividendNeg = signedMode && dividendReg[`DIV_WIDTH-1]; // Sign only counts in signed mode.
		divisorNeg = signedMode && divisorReg[`DIV_WIDTH-1];
	end

	always_comb
	begin
		if (dividendNeg)
			nextJob.dividendMag = -dividendReg;
		else
			nextJob.dividendMag = dividendReg;
		if (divisorNeg)
			nextJob.divisorMag = -divisorReg;
		else
			nextJob.divisorMag = divisorReg;
		nextJob.negQuot = dividendNeg ^ divisorNeg; // Quotient is negative when signs differ.
		nextJob.negRem = dividendNeg; // Remainder follows the dividend.
		nextJob.divByZero = (divisorReg == '0);
	end

	// Operand registers. Loads are taken even while a division runs.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			dividendReg <= '0;
			divisorReg <= '0;
		end
		else
		begin
			if (isLoadA)
				dividendReg <= cmd.load.value;
			if (isLoadB)
				divisorReg <= cmd.load.value;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			go <= 1'b0;
		else
			go <= accept; // One-cycle pulse after the accepted strobe.
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			job <= nextJob; // Held until the next accepted divide.
	end

endmodule

`default_nettype wire

// File: divExecute.sv
`default_nettype none
`timescale 1ns/1ps

`include "div_params.svh"

module divExecute
(
	input wire logic clk,
	input wire logic rst,
	input wire logic go,
	input wire divPkg::divJob_t job,
	output divPkg::divRaw_t raw,
	output logic finish,
	output logic busy
);

	localparam logic [`DIV_CNT_WIDTH-1:0] stepCount = `DIV_CNT_WIDTH'(`DIV_WIDTH);
	localparam logic [`DIV_CNT_WIDTH-1:0] lastCount = `DIV_CNT_WIDTH'(1);

	typedef enum logic [1:0]
	{
		stIdle = 2'd0,
		stRun = 2'd1,
		stFinish = 2'd2
	} execState_e;

	execState_e state;
	execState_e nextState;
	logic [`DIV_CNT_WIDTH-1:0] count;
	logic [`DIV_WIDTH-1:0] remReg;
	logic [`DIV_WIDTH-1:0] quotReg;
	logic [`DIV_WIDTH-1:0] divisorReg;
	logic [`DIV_WIDTH:0] shifted;
	logic [`DIV_WIDTH+1:0] diff;
	logic borrow;
	logic lastStep;
	logic loadJob;
	logic runStep;

	always_comb
	begin
		loadJob = (state == stIdle) && go;
		runStep = (state == stRun);
		lastStep = runStep && (count == lastCount); // Sixteenth step in flight.
	end

	// One restoring step. The next dividend bit enters the partial remainder.
	always_comb
	begin
		shifted = {remReg, quotReg[`DIV_WIDTH-1]};
		diff = {1'b0, shifted} - {2'b00, divisorReg};
		borrow = diff[`DIV_WIDTH+1]; // Set when the divisor did not fit.
	end

	always_comb
	begin
		nextState = state;
		case (state)
			stIdle:
			begin
				if (go)
					nextState = stRun;
			end
			stRun:
			begin
				if (lastStep)
					nextState = stFinish;
			end
			stFinish:
			begin
				nextState = stIdle;
			end
			default:
			begin
				nextState = stIdle;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= stIdle;
			count <= '0;
			finish <= 1'b0;
		end
		else
		begin
			state <= nextState;
			finish <= (state == stFinish); // Raw result has settled by now.
			if (loadJob)
				count <= stepCount;
			else if (runStep)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (loadJob)
		begin
			remReg <= '0;
			quotReg <= job.dividendMag; // Dividend bits shift out as quotient bits shift in.
			divisorReg <= job.divisorMag;
		end
		else if (runStep)
		begin
			if (borrow)
			begin
				remReg <= shifted[`DIV_WIDTH-1:0]; // Restore.
				quotReg <= {quotReg[`DIV_WIDTH-2:0], 1'b0};
			end
			else
			begin
				remReg <= diff[`DIV_WIDTH-1:0];
				quotReg <= {quotReg[`DIV_WIDTH-2:0], 1'b1};
			end
		end
	end

	// Busy covers the run and the settling cycle. It drops as finish rises.
	assign busy = (state != stIdle);

	always_comb
	begin
		raw.quot = quotReg;
		raw.rem = remReg;
	end

endmodule

`default_nettype wire

// File: divPkg.sv
`default_nettype none

`include "div_params.svh"

package divPkg;

	// Load view of a command word. It carries an operand value.
	typedef struct packed {
		logic [1:0] opcode;
		logic [5:0] spare;
		logic [`DIV_WIDTH-1:0] value;
	} divLoad_t;

	// Divide view of a command word. Only the mode bit matters here.
	typedef struct packed {
		logic [1:0] opcode;
		logic signedMode;
		logic [`DIV_WIDTH+4:0] spare;
	} divStart_t;

	// The opcode sits in the same bits in both views.
	typedef union packed {
		divLoad_t load;
		divStart_t start;
	} divCmd_u;

	// Operands as magnitudes with the sign fixups still to be applied.
	typedef struct packed {
		logic [`DIV_WIDTH-1:0] dividendMag;
		logic [`DIV_WIDTH-1:0] divisorMag;
		logic negQuot;
		logic negRem;
		logic divByZero;
	} divJob_t;

	// Unsigned outcome of the restoring core.
	typedef struct packed {
		logic [`DIV_WIDTH-1:0] quot;
		logic [`DIV_WIDTH-1:0] rem;
	} divRaw_t;

	// Final answer as seen at the top level.
	typedef struct packed {
		logic [`DIV_WIDTH-1:0] quotient;
		logic [`DIV_WIDTH-1:0] remainder;
		logic divByZero;
	} divResult_t;

endpackage

`default_nettype wire

// File: divResult.sv
`default_nettype none
`timescale 1ns/1ps

`include "div_params.svh"

module divResult
(
	input wire logic clk,
	input wire logic rst,
	input wire logic go,
	input wire logic finish,
	input wire divPkg::divJob_t job,
	input wire divPkg::divRaw_t raw,
	output divPkg::divResult_t result,
	output logic done
);

	logic [`DIV_WIDTH-1:0] quotFixed;
	logic [`DIV_WIDTH-1:0] remFixed;
	divPkg::divResult_t corrected;

	// Truncation toward zero falls out of negating the unsigned answer.
	always_comb
	begin
		if (job.negQuot)
			quotFixed = -raw.quot;
		else
			quotFixed = raw.quot;
		if (job.negRem)
			remFixed = -raw.rem;
		else
			remFixed = raw.rem;
	end

	always_comb
	begin
		corrected.quotient = quotFixed;
		corrected.remainder = remFixed;
		corrected.divByZero = job.divByZero; // Core output is still presented as is.
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			result <= '0;
			done <= 1'b0;
		end
		else if (finish)
		begin
			result <= corrected;
			done <= 1'b1; // Held until the next division starts.
		end
		else if (go)
		begin
			done <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: divUnit.sv
`default_nettype none
`timescale 1ns/1ps

module divUnit
(
	input wire logic clk,
	input wire logic rst,
	input wire logic cmdStrobe,
	input wire divPkg::divCmd_u cmd,
	output divPkg::divResult_t result,
	output logic done,
	output logic busy
);

	divPkg::divJob_t job;
	divPkg::divRaw_t raw;
	logic go;
	logic finish;

	divDecode decode
	(
		.clk(clk),
		.rst(rst),
		.cmdStrobe(cmdStrobe),
		.cmd(cmd),
		.busy(busy),
		.job(job),
		.go(go)
	);

	// Only one job is in flight so the decoded job stays valid to the end.
	divExecute execute
	(
		.clk(clk),
		.rst(rst),
		.go(go),
		.job(job),
		.raw(raw),
		.finish(finish),
		.busy(busy)
	);

	divResult resultStage
	(
		.clk(clk),
		.rst(rst),
		.go(go),
		.finish(finish),
		.job(job),
		.raw(raw),
		.result(result),
		.done(done)
	);

endmodule

`default_nettype wire

// File: divUnitTb.sv
`default_nettype none
`timescale 1ns/1ps

`include "div_params.svh"

module divUnitTb;

	logic clk;
	logic rst;
	logic cmdStrobe;
	divPkg::divCmd_u cmd;
	divPkg::divResult_t result;
	logic done;
	logic busy;
	logic [`DIV_WIDTH-1:0] a;
	logic [`DIV_WIDTH-1:0] b;
	int n;

	divUnit uut
	(
		.clk(clk),
		.rst(rst),
		.cmdStrobe(cmdStrobe),
		.cmd(cmd),
		.result(result),
		.done(done),
		.busy(busy)
	);

	bind divUnit divUnitChecks checks (.*);

	initial
		clk = 1'b0;

	always #10 clk = ~clk;

	// Stop at the first checker failure.
	always @(posedge clk)
	begin
		if (uut.checks.failCount != 0)
		begin
			$display("Simulation FAILED");
			$fatal(1, "The checker reported a failing assertion.");
		end
	end

	function automatic divPkg::divCmd_u loadCmd(input logic [1:0] opcode,
		input logic [`DIV_WIDTH-1:0] value);
		divPkg::divCmd_u word;
		word = '0;
		word.load.opcode = opcode;
		word.load.value = value;
		return word;
	endfunction

	function automatic divPkg::divCmd_u divideCmd(input logic signedMode);
		divPkg::divCmd_u word;
		word = '0;
		word.start.opcode = `DIV_OP_DIVIDE;
		word.start.signedMode = signedMode;
		return word;
	endfunction

	function automatic logic [`DIV_WIDTH-1:0] randWord();
		logic [31:0] r;
		r = $urandom();
		return r[`DIV_WIDTH-1:0];
	endfunction

	// Called and returns 2 ns after a rising edge.
	task automatic issue(input divPkg::divCmd_u word);
		cmd = word;
		cmdStrobe = 1'b1;
		@(posedge clk);
		#2;
		cmdStrobe = 1'b0;
		cmd = '0;
	endtask

	task automatic waitBusy();
		int cycles;
		cycles = 0;
		while (!busy && cycles < 100)
		begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (!busy)
		begin
			$display("Timeout: busy did not rise after a divide command.");
			$display("Simulation FAILED");
			$fatal(1, "Timeout waiting for busy.");
		end
	endtask

	task automatic waitDone();
		int clearCycles;
		int riseCycles;
		clearCycles = 0;
		riseCycles = 0;
		while (done && clearCycles < 100) // The previous answer is still shown at first.
		begin
			@(posedge clk);
			#2;
			clearCycles++;
		end
		if (done)
		begin
			$display("Timeout: done was not cleared by a divide command.");
			$display("Simulation FAILED");
			$fatal(1, "Timeout waiting for done to clear.");
		end
		while (!done && riseCycles < 100)
		begin
			@(posedge clk);
			#2;
			riseCycles++;
		end
		if (!done)
		begin
			$display("Timeout: done did not rise within 100 cycles of a divide.");
			$display("Simulation FAILED");
			$fatal(1, "Timeout waiting for done.");
		end
	endtask

	task automatic runDivide(input logic [`DIV_WIDTH-1:0] dividend,
		input logic [`DIV_WIDTH-1:0] divisor, input logic signedMode);
		issue(loadCmd(`DIV_OP_LOADA, dividend));
		issue(loadCmd(`DIV_OP_LOADB, divisor));
		issue(divideCmd(signedMode));
		waitDone();
	endtask

	initial
	begin
		void'($urandom(82));
		rst = 1'b1;
		cmdStrobe = 1'b0;
		cmd = '0;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;

		// Loads alone must leave the outputs in their reset state.
		issue(loadCmd(`DIV_OP_LOADA, `DIV_WIDTH'(55)));
		issue(loadCmd(`DIV_OP_LOADB, `DIV_WIDTH'(9)));
		repeat (3)
		begin
			@(posedge clk);
			#2;
		end

		for (n = 0; n < 20; n++)
		begin
			a = randWord();
			b = randWord();
			if (b == '0)
				b = `DIV_WIDTH'(1);
			runDivide(a, b, 1'b0);
		end

		runDivide(`DIV_WIDTH'(100), `DIV_WIDTH'(7), 1'b1);
		runDivide(`DIV_WIDTH'(-100), `DIV_WIDTH'(7), 1'b1);
		runDivide(`DIV_WIDTH'(100), `DIV_WIDTH'(-7), 1'b1);
		runDivide(`DIV_WIDTH'(-100), `DIV_WIDTH'(-7), 1'b1);
		runDivide(`DIV_WIDTH'(-32768), `DIV_WIDTH'(-1), 1'b1); // Wraps in two's complement.
		for (n = 0; n < 20; n++)
		begin
			a = randWord();
			b = randWord();
			if (b == '0)
				b = `DIV_WIDTH'(-3);
			runDivide(a, b, 1'b1);
		end

		runDivide(randWord(), '0, 1'b0);
		runDivide(`DIV_WIDTH'(4321), '0, 1'b0);
		runDivide(`DIV_WIDTH'(-1234), '0, 1'b1);

		// A divide while busy is dropped and a load only affects the next job.
		issue(loadCmd(`DIV_OP_LOADA, `DIV_WIDTH'(1000)));
		issue(loadCmd(`DIV_OP_LOADB, `DIV_WIDTH'(7)));
		issue(divideCmd(1'b0));
		waitBusy();
		issue(loadCmd(`DIV_OP_LOADA, `DIV_WIDTH'(-500)));
		issue(loadCmd(`DIV_OP_LOADB, `DIV_WIDTH'(3)));
		issue(divideCmd(1'b1)); // Taking this would flip the signs of the running job.
		waitDone();
		issue(divideCmd(1'b1));
		waitDone();

		repeat (3)
		begin
			@(posedge clk);
			#2;
		end
		if (uut.checks.failCount == 0)
		begin
			$display("Simulation PASSED");
			$finish;
		end
		else
		begin
			$display("Simulation FAILED");
			$fatal(1, "The checker reported a failing assertion.");
		end
	end

endmodule

`default_nettype wire

// File: divUnit_assertions.sv
`default_nettype none
`timescale 1ns/1ps

`include "div_params.svh"

module divUnitChecks
(
	input wire logic clk,
	input wire logic rst,
	input wire logic cmdStrobe,
	input wire divPkg::divCmd_u cmd,
	input wire divPkg::divResult_t result,
	input wire logic done,
	input wire logic busy
);

	// Phase k is what the k-th edge after an accepted divide strobe samples.
	localparam int lastBusy = `DIV_WIDTH + 2;
	localparam int finishCycle = `DIV_WIDTH + 3;
	localparam int doneCycle = `DIV_WIDTH + 4;

	int failCount = 0;
	int phase;
	logic [`DIV_WIDTH-1:0] shadowA;
	logic [`DIV_WIDTH-1:0] shadowB;
	logic [`DIV_WIDTH-1:0] expQuot;
	logic [`DIV_WIDTH-1:0] expRem;
	logic expZero;
	logic checkQuot;
	logic goShadow;
	logic started;
	logic acceptNow;
	logic signedMode;
	logic signed [31:0] numer;
	logic signed [31:0] denom;
	logic signed [31:0] quotWide;
	logic signed [31:0] remWide;

	always_comb
	begin
		signedMode = cmd.start.signedMode;
		acceptNow = cmdStrobe && (cmd.start.opcode == `DIV_OP_DIVIDE) && !busy && !goShadow;
		if (signedMode)
		begin
			numer = 32'($signed(shadowA));
			denom = 32'($signed(shadowB));
		end
		else
		begin
			numer = 32'(shadowA);
			denom = 32'(shadowB);
		end
		if (denom != 0)
		begin
			quotWide = numer / denom; // Truncates toward zero, remainder keeps the dividend sign.
			remWide = numer % denom;
		end
		else
		begin
			quotWide = '1;
			remWide = numer;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			shadowA <= '0;
			shadowB <= '0;
			goShadow <= 1'b0;
			started <= 1'b0;
			phase <= 0;
		end
		else
		begin
			if (cmdStrobe && cmd.load.opcode == `DIV_OP_LOADA)
				shadowA <= cmd.load.value;
			if (cmdStrobe && cmd.load.opcode == `DIV_OP_LOADB)
				shadowB <= cmd.load.value;
			goShadow <= acceptNow;
			if (acceptNow)
			begin
				started <= 1'b1;
				phase <= 1;
				expQuot <= quotWide[`DIV_WIDTH-1:0];
				expRem <= remWide[`DIV_WIDTH-1:0];
				expZero <= (denom == 0);
				checkQuot <= !signedMode || (denom != 0); // Signed zero divide leaves the quotient open.
			end
			else if (phase != 0 && phase != doneCycle)
				phase <= phase + 1;
			else
				phase <= 0;
		end
	end

	resetState: assert property (@(posedge clk) disable iff (rst)
		!started |-> (!done && !busy && result == '0))
	else
	begin
		failCount++;
		$error("FAIL at %0t: outputs left the reset state before any divide", $time);
	end

	busyWindow: assert property (@(posedge clk) disable iff (rst)
		(phase >= 2 && phase <= lastBusy) |-> (busy && !done))
	else
	begin
		failCount++;
		$error("FAIL at %0t: busy low or done high during phase %0d", $time, phase);
	end

	finishEdge: assert property (@(posedge clk) disable iff (rst)
		(phase == finishCycle) |-> (!busy && !done))
	else
	begin
		failCount++;
		$error("FAIL at %0t: busy or done wrong on the finish cycle", $time);
	end

	doneRise: assert property (@(posedge clk) disable iff (rst)
		(phase == doneCycle) |-> done)
	else
	begin
		failCount++;
		$error("FAIL at %0t: done did not rise at the fixed latency", $time);
	end

	resultValue: assert property (@(posedge clk) disable iff (rst)
		(phase == doneCycle) |-> (result.remainder == expRem && result.divByZero == expZero
			&& (!checkQuot || result.quotient == expQuot)))
	else
	begin
		failCount++;
		$error("FAIL at %0t: result %h/%h/%b, expected %h/%h/%b", $time, result.quotient,
			result.remainder, result.divByZero, expQuot, expRem, expZero);
	end

	holdStable: assert property (@(posedge clk) disable iff (rst)
		(done && $past(done)) |-> $stable(result))
	else
	begin
		failCount++;
		$error("FAIL at %0t: result changed while done was held", $time);
	end

endmodule

`default_nettype wire

// File: div_params.svh
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// Operand width. The dividend, divisor, quotient and remainder all share it.
`define DIV_WIDTH 16

// The iteration counter must be able to hold DIV_WIDTH itself.
`define DIV_CNT_WIDTH 5

// Command opcodes in the top two bits of a command word.
// Code 2'b00 is not a command and is ignored by the decoder.
`define DIV_OP_LOADA 2'b01
`define DIV_OP_LOADB 2'b10
`define DIV_OP_DIVIDE 2'b11

`endif

// File: list.f
+incdir+.
divPkg.sv
divDecode.sv
divExecute.sv
divResult.sv
divUnit.sv
divUnit_assertions.sv
divUnitTb.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module divUnitTb -f list.f -o divUnitTbSim

# Keep running after an assertion error so the testbench can report it.
output=$(./obj_dir/divUnitTbSim +verilator+error+limit+1000 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Simulation PASSED"; then
	exit 0
else
	exit 1
fi
